/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --assert -Wno-fatal
TOP       = tb_mfpu
FILELIST  = sim.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status
	! grep -qF "*** FAILED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* mfpu_pkg.sv */
// Vector multiply unit definitions
package mfpu_pkg;

  // Datapath word and its byte enables
  localparam int unsigned ElenWidth = 64;
  localparam int unsigned StrbWidth = ElenWidth / 8;

  // Instruction ids that can be in flight
  localparam int unsigned NrVInsn = 4;

  typedef logic [ElenWidth-1:0]       elen_t;
  typedef logic [StrbWidth-1:0]       strb_t;
  // Vector length in elements, up to 512
  typedef logic [9:0]                 vlen_t;
  typedef logic [7:0]                 vaddr_t;
  typedef logic [$clog2(NrVInsn)-1:0] vid_t;

  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  typedef enum logic [1:0] {
    VMUL  = 2'd0,
    VMULH = 2'd1,
    VMACC = 2'd2
  } mul_op_e;

  // Elements packed into one 64-bit beat
  function automatic logic [3:0] elems_per_beat(vsew_e vsew);
    logic [3:0] n;
    case (vsew)
      EW8:     n = 4'd8;
      EW16:    n = 4'd4;
      EW32:    n = 4'd2;
      default: n = 4'd1;
    endcase
    return n;
  endfunction

endpackage

/* mfpu_props.sv */
// Register file port checks
module mfpu_props (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         req_i,
  input logic                         gnt_i,
  input mfpu_pkg::vaddr_t             addr_i,
  input mfpu_pkg::vid_t               id_i,
  input mfpu_pkg::elen_t              wdata_i,
  input mfpu_pkg::strb_t              be_i,
  input logic [mfpu_pkg::NrVInsn-1:0] done_i
);

  // Head entry holds until the register file takes it
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !gnt_i |=> req_i && $stable(addr_i) && $stable(id_i) &&
                        $stable(wdata_i) && $stable(be_i))
    else $error("Request dropped or payload changed before its grant");

  // Done bits are one-hot and each pulse lasts a single cycle
  done_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(done_i) && (done_i & $past(done_i)) == '0)
    else $error("Done bits not one-hot or held for more than one cycle");

  // Port is quiet in the first cycle out of reset
  reset_quiet: assert property (@(posedge clk_i) $rose(rst_ni) |-> !req_i && done_i == '0)
    else $error("Request or done active right after reset");

  gnt_with_req: assert property (@(posedge clk_i) disable iff (!rst_ni) gnt_i |-> req_i)
    else $error("Grant given without a pending request");

endmodule

bind mfpu_result_queue mfpu_props i_props (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .req_i  (result_req_o),
  .gnt_i  (result_gnt_i),
  .addr_i (result_addr_o),
  .id_i   (result_id_o),
  .wdata_i(result_wdata_o),
  .be_i   (result_be_o),
  .done_i (vinsn_done_o)
);

/* mfpu_result_queue.sv */
// Result queue toward the register file
module mfpu_result_queue (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Result beats from the multiplier
  input  logic                         mul_valid_i,
  input  mfpu_pkg::elen_t              mul_wdata_i,
  input  mfpu_pkg::vaddr_t             mul_addr_i,
  input  mfpu_pkg::strb_t              mul_be_i,
  input  mfpu_pkg::vid_t               mul_id_i,
  input  logic                         mul_last_i,
  output logic                         rq_ready_o,
  // Register file write port
  output logic                         result_req_o,
  output mfpu_pkg::vaddr_t             result_addr_o,
  output mfpu_pkg::vid_t               result_id_o,
  output mfpu_pkg::elen_t              result_wdata_o,
  output mfpu_pkg::strb_t              result_be_o,
  input  logic                         result_gnt_i,
  // Completion toward sequencer and instruction queue
  output logic [mfpu_pkg::NrVInsn-1:0] vinsn_done_o,
  output logic                         commit_o
);
  import mfpu_pkg::*;

  localparam int unsigned ResultQueueDepth = 2;
  localparam int unsigned PtrWidth         = $clog2(ResultQueueDepth);

  elen_t  wdata_q [ResultQueueDepth];
  vaddr_t addr_q  [ResultQueueDepth];
  strb_t  be_q    [ResultQueueDepth];
  vid_t   id_q    [ResultQueueDepth];
  logic   last_q  [ResultQueueDepth];

  logic [PtrWidth-1:0] wr_pnt_q, rd_pnt_q;
  logic [PtrWidth:0]   cnt_q;
  logic                push, pop;

  assign rq_ready_o = (cnt_q != (PtrWidth+1)'(ResultQueueDepth));
  assign push       = mul_valid_i && rq_ready_o;

  // Head entry is presented until the register file grants it
  assign result_req_o   = (cnt_q != '0);
  assign result_addr_o  = addr_q[rd_pnt_q];
  assign result_id_o    = id_q[rd_pnt_q];
  assign result_wdata_o = wdata_q[rd_pnt_q];
  assign result_be_o    = be_q[rd_pnt_q];
  assign pop            = result_req_o && result_gnt_i;

  // Last beat written back, instruction is complete
  always_comb begin
    vinsn_done_o = '0;
    commit_o     = pop && last_q[rd_pnt_q];
    if (commit_o)
      vinsn_done_o[result_id_o] = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      wdata_q[wr_pnt_q] <= mul_wdata_i;
      addr_q[wr_pnt_q]  <= mul_addr_i;
      be_q[wr_pnt_q]    <= mul_be_i;
      id_q[wr_pnt_q]    <= mul_id_i;
      last_q[wr_pnt_q]  <= mul_last_i;
    end
  end

  // Power-of-two depth, pointers wrap on their own
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push)
        wr_pnt_q <= wr_pnt_q + 1'b1;
      if (pop)
        rd_pnt_q <= rd_pnt_q + 1'b1;
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

/* mfpu_simd_mul.sv */
// Pipelined SIMD integer multiplier
module mfpu_simd_mul #(
  parameter int unsigned MulLatency = 2
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Beat from the instruction queue
  input  logic              iss_valid_i,
  input  mfpu_pkg::mul_op_e iss_op_i,
  input  mfpu_pkg::vsew_e   iss_vsew_i,
  input  mfpu_pkg::elen_t   iss_a_i,
  input  mfpu_pkg::elen_t   iss_b_i,
  input  mfpu_pkg::elen_t   iss_c_i,
  input  mfpu_pkg::vaddr_t  iss_addr_i,
  input  mfpu_pkg::strb_t   iss_be_i,
  input  mfpu_pkg::vid_t    iss_id_i,
  input  logic              iss_last_i,
  output logic              mul_ready_o,
  // Result beat
  output logic              mul_valid_o,
  output mfpu_pkg::elen_t   mul_wdata_o,
  output mfpu_pkg::vaddr_t  mul_addr_o,
  output mfpu_pkg::strb_t   mul_be_o,
  output mfpu_pkg::vid_t    mul_id_o,
  output logic              mul_last_o,
  input  logic              rq_ready_i
);
  import mfpu_pkg::*;

  // One full-word result per element width, index is the vsew encoding
  logic [3:0][ElenWidth-1:0] res_ew;
  elen_t                     res;

  for (genvar k = 0; k < 4; k++) begin : gen_ew
    localparam int unsigned W = 8 << k;
    for (genvar e = 0; e < ElenWidth / W; e++) begin : gen_elem
      logic signed [2*W-1:0] prod;
      // Low half is the same for signed and unsigned operands
      assign prod = $signed(iss_a_i[e*W +: W]) * $signed(iss_b_i[e*W +: W]);
      assign res_ew[k][e*W +: W] = (iss_op_i == VMULH) ? prod[2*W-1:W] :
                                   (iss_op_i == VMACC) ? iss_c_i[e*W +: W] + prod[W-1:0] :
                                   prod[W-1:0];
    end
  end

  assign res = res_ew[iss_vsew_i];

  logic   vld_q  [MulLatency];
  elen_t  data_q [MulLatency];
  vaddr_t addr_q [MulLatency];
  strb_t  be_q   [MulLatency];
  vid_t   id_q   [MulLatency];
  logic   last_q [MulLatency];
  logic   advance;

  // Whole pipe holds while the output beat is not taken
  assign advance     = !(vld_q[MulLatency-1] && !rq_ready_i);
  assign mul_ready_o = advance;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < MulLatency; s++)
        vld_q[s] <= 1'b0;
    end else if (advance) begin
      vld_q[0] <= iss_valid_i;
      for (int s = 1; s < MulLatency; s++)
        vld_q[s] <= vld_q[s-1];
    end
  end

  // Metadata rides along with the product
  always_ff @(posedge clk_i) begin
    if (advance) begin
      data_q[0] <= res;
      addr_q[0] <= iss_addr_i;
      be_q[0]   <= iss_be_i;
      id_q[0]   <= iss_id_i;
      last_q[0] <= iss_last_i;
      for (int s = 1; s < MulLatency; s++) begin
        data_q[s] <= data_q[s-1];
        addr_q[s] <= addr_q[s-1];
        be_q[s]   <= be_q[s-1];
        id_q[s]   <= id_q[s-1];
        last_q[s] <= last_q[s-1];
      end
    end
  end

  assign mul_valid_o = vld_q[MulLatency-1];
  assign mul_wdata_o = data_q[MulLatency-1];
  assign mul_addr_o  = addr_q[MulLatency-1];
  assign mul_be_o    = be_q[MulLatency-1];
  assign mul_id_o    = id_q[MulLatency-1];
  assign mul_last_o  = last_q[MulLatency-1];

endmodule

/* mfpu_top.sv */
// Vector multiply unit top level
module mfpu_top #(
  parameter int unsigned VInsnQueueDepth = 4,
  parameter int unsigned MulLatency      = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // Sequencer
  input  mfpu_pkg::mul_op_e            op_i,
  input  mfpu_pkg::vsew_e              vsew_i,
  input  mfpu_pkg::vlen_t              vl_i,
  input  mfpu_pkg::vaddr_t             vd_i,
  input  mfpu_pkg::vid_t               id_i,
  input  logic                         vm_i,
  input  logic                         use_scalar_i,
  input  mfpu_pkg::elen_t              scalar_i,
  input  logic                         op_valid_i,
  output logic                         op_ready_o,
  output logic [mfpu_pkg::NrVInsn-1:0] vinsn_done_o,
  // Operand queues
  input  mfpu_pkg::elen_t              operand_a_i,
  input  mfpu_pkg::elen_t              operand_b_i,
  input  mfpu_pkg::elen_t              operand_c_i,
  input  mfpu_pkg::strb_t              mask_i,
  input  logic                         operand_valid_i,
  output logic                         operand_ready_o,
  // Register file
  output logic                         result_req_o,
  output mfpu_pkg::vaddr_t             result_addr_o,
  output mfpu_pkg::vid_t               result_id_o,
  output mfpu_pkg::elen_t              result_wdata_o,
  output mfpu_pkg::strb_t              result_be_o,
  input  logic                         result_gnt_i
);
  import mfpu_pkg::*;

  // Issue path
  logic    iss_valid, iss_last, mul_ready;
  mul_op_e iss_op;
  vsew_e   iss_vsew;
  elen_t   iss_a, iss_b, iss_c;
  vaddr_t  iss_addr;
  strb_t   iss_be;
  vid_t    iss_id;
  // Result path
  logic    mul_valid, mul_last, rq_ready, commit;
  elen_t   mul_wdata;
  vaddr_t  mul_addr;
  strb_t   mul_be;
  vid_t    mul_id;

  mfpu_vinsn_queue #(
    .VInsnQueueDepth(VInsnQueueDepth)
  ) i_vinsn_queue (
    .iss_valid_o(iss_valid),
    .iss_op_o   (iss_op),
    .iss_vsew_o (iss_vsew),
    .iss_a_o    (iss_a),
    .iss_b_o    (iss_b),
    .iss_c_o    (iss_c),
    .iss_addr_o (iss_addr),
    .iss_be_o   (iss_be),
    .iss_id_o   (iss_id),
    .iss_last_o (iss_last),
    .mul_ready_i(mul_ready),
    .commit_i   (commit),
    .*
  );

  mfpu_simd_mul #(
    .MulLatency(MulLatency)
  ) i_simd_mul (
    .iss_valid_i(iss_valid),
    .iss_op_i   (iss_op),
    .iss_vsew_i (iss_vsew),
    .iss_a_i    (iss_a),
    .iss_b_i    (iss_b),
    .iss_c_i    (iss_c),
    .iss_addr_i (iss_addr),
    .iss_be_i   (iss_be),
    .iss_id_i   (iss_id),
    .iss_last_i (iss_last),
    .mul_ready_o(mul_ready),
    .mul_valid_o(mul_valid),
    .mul_wdata_o(mul_wdata),
    .mul_addr_o (mul_addr),
    .mul_be_o   (mul_be),
    .mul_id_o   (mul_id),
    .mul_last_o (mul_last),
    .rq_ready_i (rq_ready),
    .*
  );

  mfpu_result_queue i_result_queue (
    .mul_valid_i(mul_valid),
    .mul_wdata_i(mul_wdata),
    .mul_addr_i (mul_addr),
    .mul_be_i   (mul_be),
    .mul_id_i   (mul_id),
    .mul_last_i (mul_last),
    .rq_ready_o (rq_ready),
    .commit_o   (commit),
    .*
  );

endmodule

/* mfpu_vinsn_queue.sv */
// Vector instruction queue and beat issue
module mfpu_vinsn_queue #(
  parameter int unsigned VInsnQueueDepth = 4
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  // Instruction from the sequencer
  input  mfpu_pkg::mul_op_e op_i,
  input  mfpu_pkg::vsew_e   vsew_i,
  input  mfpu_pkg::vlen_t   vl_i,
  input  mfpu_pkg::vaddr_t  vd_i,
  input  mfpu_pkg::vid_t    id_i,
  input  logic              vm_i,
  input  logic              use_scalar_i,
  input  mfpu_pkg::elen_t   scalar_i,
  input  logic              op_valid_i,
  output logic              op_ready_o,
  // Operand bundle, mask travels along
  input  mfpu_pkg::elen_t   operand_a_i,
  input  mfpu_pkg::elen_t   operand_b_i,
  input  mfpu_pkg::elen_t   operand_c_i,
  input  mfpu_pkg::strb_t   mask_i,
  input  logic              operand_valid_i,
  output logic              operand_ready_o,
  // Beat toward the multiplier
  output logic              iss_valid_o,
  output mfpu_pkg::mul_op_e iss_op_o,
  output mfpu_pkg::vsew_e   iss_vsew_o,
  output mfpu_pkg::elen_t   iss_a_o,
  output mfpu_pkg::elen_t   iss_b_o,
  output mfpu_pkg::elen_t   iss_c_o,
  output mfpu_pkg::vaddr_t  iss_addr_o,
  output mfpu_pkg::strb_t   iss_be_o,
  output mfpu_pkg::vid_t    iss_id_o,
  output logic              iss_last_o,
  input  logic              mul_ready_i,
  input  logic              commit_i
);
  import mfpu_pkg::*;

  localparam int unsigned PtrWidth = (VInsnQueueDepth > 1) ? $clog2(VInsnQueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(VInsnQueueDepth + 1);

  // Instruction storage
  mul_op_e op_q         [VInsnQueueDepth];
  vsew_e   vsew_q       [VInsnQueueDepth];
  vlen_t   vl_q         [VInsnQueueDepth];
  vaddr_t  vd_q         [VInsnQueueDepth];
  vid_t    id_q         [VInsnQueueDepth];
  logic    vm_q         [VInsnQueueDepth];
  logic    use_scalar_q [VInsnQueueDepth];
  elen_t   scalar_q     [VInsnQueueDepth];

  logic [PtrWidth-1:0] accept_pnt_q, issue_pnt_q, issue_pnt_d;
  logic [CntWidth-1:0] issue_cnt_q, issue_cnt_d, commit_cnt_q;
  // Elements still to issue and beat index of the head instruction
  vlen_t               rem_q, rem_d;
  vaddr_t              beat_q, beat_d;
  logic                init_q;
  logic                full, accept, issue_fire;
  logic [3:0]          epb, n_elems;
  strb_t               tail_be;
  elen_t               scalar_rep;

  function automatic logic [PtrWidth-1:0] next_pnt(logic [PtrWidth-1:0] pnt);
    return (pnt == PtrWidth'(VInsnQueueDepth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  assign full       = (commit_cnt_q == CntWidth'(VInsnQueueDepth));
  assign op_ready_o = init_q && !full;
  assign accept     = op_valid_i && op_ready_o;

  assign iss_valid_o     = (issue_cnt_q != '0) && operand_valid_i;
  assign issue_fire      = iss_valid_o && mul_ready_i;
  assign operand_ready_o = issue_fire;

  assign iss_op_o   = op_q[issue_pnt_q];
  assign iss_vsew_o = vsew_q[issue_pnt_q];
  assign iss_id_o   = id_q[issue_pnt_q];
  assign iss_b_o    = operand_b_i;
  assign iss_c_o    = operand_c_i;
  assign iss_addr_o = vd_q[issue_pnt_q] + beat_q;
  assign iss_a_o    = use_scalar_q[issue_pnt_q] ? scalar_rep : operand_a_i;

  // Scalar copied into every element slot of the word
  always_comb begin
    case (iss_vsew_o)
      EW8:     scalar_rep = {8{scalar_q[issue_pnt_q][7:0]}};
      EW16:    scalar_rep = {4{scalar_q[issue_pnt_q][15:0]}};
      EW32:    scalar_rep = {2{scalar_q[issue_pnt_q][31:0]}};
      default: scalar_rep = scalar_q[issue_pnt_q];
    endcase
  end

  // Tail of the vector: only elements below vl are written
  always_comb begin
    epb        = elems_per_beat(iss_vsew_o);
    iss_last_o = (rem_q <= vlen_t'(epb));
    n_elems    = iss_last_o ? rem_q[3:0] : epb;
    for (int b = 0; b < StrbWidth; b++)
      tail_be[b] = (b >> int'(iss_vsew_o)) < int'(n_elems);
    iss_be_o = tail_be & (vm_q[issue_pnt_q] ? {StrbWidth{1'b1}} : mask_i);
  end

  always_comb begin
    issue_pnt_d = issue_pnt_q;
    issue_cnt_d = issue_cnt_q;
    rem_d       = rem_q;
    beat_d      = beat_q;
    if (issue_fire) begin
      rem_d  = rem_q - vlen_t'(n_elems);
      beat_d = beat_q + 1'b1;
      if (iss_last_o) begin
        issue_pnt_d = next_pnt(issue_pnt_q);
        issue_cnt_d = issue_cnt_q - 1'b1;
        beat_d      = '0;
        if (issue_cnt_d != '0)
          rem_d = vl_q[issue_pnt_d];
      end
    end
    // A new instruction into an idle issue stage starts counting at once
    if (accept) begin
      if (issue_cnt_d == '0)
        rem_d = vl_i;
      issue_cnt_d = issue_cnt_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q[accept_pnt_q]         <= op_i;
      vsew_q[accept_pnt_q]       <= vsew_i;
      vl_q[accept_pnt_q]         <= vl_i;
      vd_q[accept_pnt_q]         <= vd_i;
      id_q[accept_pnt_q]         <= id_i;
      vm_q[accept_pnt_q]         <= vm_i;
      use_scalar_q[accept_pnt_q] <= use_scalar_i;
      scalar_q[accept_pnt_q]     <= scalar_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      init_q       <= 1'b0;
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      rem_q        <= '0;
      beat_q       <= '0;
    end else begin
      init_q      <= 1'b1;
      issue_pnt_q <= issue_pnt_d;
      issue_cnt_q <= issue_cnt_d;
      rem_q       <= rem_d;
      beat_q      <= beat_d;
      if (accept)
        accept_pnt_q <= next_pnt(accept_pnt_q);
      // Slot stays taken until its last beat is written back
      if (accept && !commit_i)
        commit_cnt_q <= commit_cnt_q + 1'b1;
      else if (!accept && commit_i)
        commit_cnt_q <= commit_cnt_q - 1'b1;
    end
  end

endmodule

/* sim.f */
mfpu_pkg.sv
mfpu_vinsn_queue.sv
mfpu_simd_mul.sv
mfpu_result_queue.sv
mfpu_top.sv
mfpu_props.sv
tb_mfpu.sv

/* tb_mfpu.sv */
// Vector multiply unit testbench
module tb_mfpu;
  import mfpu_pkg::*;

  localparam int NrInsn = 14;

  typedef struct packed {
    elen_t      data;
    vaddr_t     addr;
    strb_t      be;
    logic       last;
    logic [4:0] k;
  } beat_t;

  logic               clk_i, rst_ni;
  mul_op_e            op_i;
  vsew_e              vsew_i;
  vlen_t              vl_i;
  vaddr_t             vd_i, result_addr_o;
  vid_t               id_i, result_id_o;
  logic               vm_i, use_scalar_i, op_valid_i, op_ready_o;
  elen_t              scalar_i, operand_a_i, operand_b_i, operand_c_i, result_wdata_o;
  strb_t              mask_i, result_be_o;
  logic               operand_valid_i, operand_ready_o, result_req_o, result_gnt_i;
  logic [NrVInsn-1:0] vinsn_done_o;

  // Instruction list, index k is also the accept order
  string   ins_name   [NrInsn];
  mul_op_e ins_op     [NrInsn];
  vsew_e   ins_vsew   [NrInsn];
  int      ins_vl     [NrInsn];
  vaddr_t  ins_vd     [NrInsn];
  logic    ins_vm     [NrInsn];
  logic    ins_us     [NrInsn];
  elen_t   ins_scalar [NrInsn];

  beat_t       exp_q [$];
  logic [31:0] lfsr = 32'ha575af95;
  int          errors, n_beats, n_done, total_beats, limit, cycles;
  int          iss_k, iss_beat, iss_elems;
  logic        opnd_taken, req_seen, hold_gnt;

  mfpu_top #(
    .VInsnQueueDepth(4),
    .MulLatency     (2)
  ) UUT (.*);

  always #50 clk_i = ~clk_i;

  // Galois LFSR, one step per random bit
  function automatic logic rand_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b)
      lfsr = lfsr ^ 32'h80200003;
    return b;
  endfunction

  function automatic elen_t rand_word(int n);
    elen_t w;
    w = '0;
    for (int i = 0; i < n; i++)
      w = {w[62:0], rand_bit()};
    return w;
  endfunction

  task automatic add_insn(int k, string name, mul_op_e op, vsew_e vsew, int vl,
                          vaddr_t vd, logic vm, logic us);
    ins_name[k]   = name;
    ins_op[k]     = op;
    ins_vsew[k]   = vsew;
    ins_vl[k]     = vl;
    ins_vd[k]     = vd;
    ins_vm[k]     = vm;
    ins_us[k]     = us;
    ins_scalar[k] = rand_word(64);
    total_beats  += (vl + (8 >> int'(vsew)) - 1) / (8 >> int'(vsew));
  endtask

  // Expected write of one beat, rem is the count of elements not yet issued
  function automatic beat_t ref_beat(int k, elen_t a, elen_t b, elen_t c, strb_t m,
                                     int beat, int rem);
    beat_t               r;
    int                  w, epb, n;
    logic [127:0]        msk, ea, eb, ec, e;
    logic signed [127:0] sa, sb, p;
    w   = 8 << int'(ins_vsew[k]);
    epb = 64 / w;
    n   = (rem < epb) ? rem : epb;
    msk = (128'd1 << w) - 1;
    r   = '0;
    for (int i = 0; i < epb; i++) begin
      ea = ins_us[k] ? (128'(ins_scalar[k]) & msk) : ((128'(a) >> (i * w)) & msk);
      eb = (128'(b) >> (i * w)) & msk;
      ec = (128'(c) >> (i * w)) & msk;
      sa = $signed(ea << (128 - w)) >>> (128 - w);
      sb = $signed(eb << (128 - w)) >>> (128 - w);
      p  = sa * sb;
      case (ins_op[k])
        VMULH:   e = (p >> w) & msk;
        VMACC:   e = (ec + p) & msk;
        default: e = p & msk;
      endcase
      r.data = r.data | elen_t'(e << (i * w));
      if (i < n)
        r.be = r.be | strb_t'(((1 << (w / 8)) - 1) << (i * w / 8));
    end
    if (!ins_vm[k])
      r.be = r.be & m;
    r.addr = ins_vd[k] + vaddr_t'(beat);
    r.last = (rem <= epb);
    r.k    = 5'(k);
    return r;
  endfunction

  task automatic check_val(string name, string field, logic [63:0] want, logic [63:0] got);
    assert (want == got) else begin
      errors++;
      $display("Error: %s %s expected %h actual %h", name, field, want, got);
    end
  endtask

  task automatic drive_insn(int k);
    @(posedge clk_i);
    op_valid_i   <= 1'b1;
    op_i         <= ins_op[k];
    vsew_i       <= ins_vsew[k];
    vl_i         <= vlen_t'(ins_vl[k]);
    vd_i         <= ins_vd[k];
    id_i         <= vid_t'(k % 4);
    vm_i         <= ins_vm[k];
    use_scalar_i <= ins_us[k];
    scalar_i     <= ins_scalar[k];
  endtask

  task automatic wait_accept();
    do
      @(negedge clk_i);
    while (!op_ready_o);
  endtask

  task automatic send_insn(int k);
    drive_insn(k);
    wait_accept();
  endtask

  task automatic report_and_finish(bit timed_out);
    $display("Checked %0d beats and %0d done pulses with %0d errors", n_beats, n_done, errors);
    if (errors == 0 && !timed_out)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  endtask

  // Operand stream and register file grant
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (!operand_valid_i || opnd_taken) begin
        operand_valid_i <= rand_bit() | rand_bit();
        operand_a_i     <= rand_word(64);
        operand_b_i     <= rand_word(64);
        operand_c_i     <= rand_word(64);
        mask_i          <= strb_t'(rand_word(8));
      end
      // At most every other cycle, so req is still high when the grant lands
      result_gnt_i <= req_seen && !result_gnt_i && !hold_gnt && rand_bit();
    end
  end

  // Scoreboard
  always @(negedge clk_i) begin
    beat_t              exp;
    logic [NrVInsn-1:0] want_done;
    opnd_taken = operand_valid_i && operand_ready_o;
    req_seen   = result_req_o;
    want_done  = '0;
    if (operand_ready_o) begin
      exp = ref_beat(iss_k, operand_a_i, operand_b_i, operand_c_i, mask_i, iss_beat,
                     ins_vl[iss_k] - iss_elems);
      exp_q.push_back(exp);
      iss_beat++;
      iss_elems += 8 >> int'(ins_vsew[iss_k]);
      if (exp.last) begin
        iss_k++;
        iss_beat  = 0;
        iss_elems = 0;
      end
    end
    if (result_req_o && result_gnt_i) begin
      assert (exp_q.size() != 0) else begin
        errors++;
        $display("A beat was written to the register file that was never issued");
      end
      if (exp_q.size() != 0) begin
        exp = exp_q.pop_front();
        check_val(ins_name[exp.k], "wdata", exp.data, result_wdata_o);
        check_val(ins_name[exp.k], "addr", 64'(exp.addr), 64'(result_addr_o));
        check_val(ins_name[exp.k], "be", 64'(exp.be), 64'(result_be_o));
        check_val(ins_name[exp.k], "id", 64'(exp.k % 4), 64'(result_id_o));
        n_beats++;
        if (exp.last)
          want_done[exp.k[1:0]] = 1'b1;
      end
    end
    assert (vinsn_done_o == want_done) else begin
      errors++;
      $display("Error: done_pulse expected %b actual %b", want_done, vinsn_done_o);
    end
    if (vinsn_done_o != '0)
      n_done++;
  end

  initial begin
    wait (rst_ni);
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    report_and_finish(1'b1);
  end

  initial begin
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    op_valid_i      = 1'b0;
    op_i            = VMUL;
    vsew_i          = EW8;
    vl_i            = '0;
    vd_i            = '0;
    id_i            = '0;
    vm_i            = 1'b0;
    use_scalar_i    = 1'b0;
    scalar_i        = '0;
    operand_a_i     = '0;
    operand_b_i     = '0;
    operand_c_i     = '0;
    mask_i          = '0;
    operand_valid_i = 1'b0;
    result_gnt_i    = 1'b0;
    opnd_taken      = 1'b0;
    req_seen        = 1'b0;
    hold_gnt        = 1'b0;
    add_insn(0, "vmul_ew8", VMUL, EW8, 16, 8'h10, 1'b1, 1'b0);
    add_insn(1, "vmul_ew16", VMUL, EW16, 8, 8'h20, 1'b1, 1'b0);
    add_insn(2, "vmul_ew32", VMUL, EW32, 6, 8'h30, 1'b1, 1'b0);
    add_insn(3, "vmul_ew64", VMUL, EW64, 3, 8'h40, 1'b1, 1'b0);
    add_insn(4, "vmulh_scalar_ew16", VMULH, EW16, 12, 8'h50, 1'b1, 1'b1);
    add_insn(5, "vmacc_scalar_ew32", VMACC, EW32, 4, 8'h60, 1'b1, 1'b1);
    add_insn(6, "vmulh_scalar_ew64", VMULH, EW64, 2, 8'h68, 1'b1, 1'b1);
    add_insn(7, "tail_mask_ew8", VMUL, EW8, 13, 8'h70, 1'b0, 1'b0);
    add_insn(8, "tail_mask_ew16", VMACC, EW16, 7, 8'h80, 1'b0, 1'b0);
    for (int k = 9; k < NrInsn; k++)
      add_insn(k, "queue_full", VMUL, EW32, 4, vaddr_t'(8'h90 + 2 * k), 1'b1, 1'b0);
    limit = 20 * total_beats + 200;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    assert (!op_ready_o && !operand_ready_o) else begin
      errors++;
      $display("op_ready_o or operand_ready_o was high in the first cycle after reset");
    end
    for (int k = 0; k < 9; k++)
      send_insn(k);
    @(posedge clk_i);
    op_valid_i <= 1'b0;
    wait (n_done == 9);
    // Grant held low, so no slot frees while five instructions arrive
    hold_gnt = 1'b1;
    for (int k = 9; k < 13; k++)
      send_insn(k);
    drive_insn(13);
    repeat (16) begin
      @(negedge clk_i);
      assert (!op_ready_o) else begin
        errors++;
        $display("op_ready_o was high while four instructions were outstanding");
      end
    end
    hold_gnt = 1'b0;
    wait_accept();
    assert (n_done > 9) else begin
      errors++;
      $display("The fifth instruction was accepted before any done pulse");
    end
    @(posedge clk_i);
    op_valid_i <= 1'b0;
    wait (n_done == NrInsn);
    repeat (10) @(negedge clk_i);
    check_val("end_of_run", "beats", 64'(total_beats), 64'(n_beats));
    check_val("end_of_run", "pending", 64'd0, 64'(exp_q.size()));
    check_val("end_of_run", "dones", 64'(NrInsn), 64'(n_done));
    report_and_finish(1'b0);
  end

endmodule
